//--- lsu_top.f
src/lsu_cfg_pkg.sv
src/lsu_op_pkg.sv
src/lsu_request_gen.sv
src/lsu_txn_ctrl.sv
src/lsu_rdata_align.sv
src/lsu_top.sv
testbench/tb_clk_gen.sv
testbench/tb_mem_model.sv
testbench/tb_lsu_top.sv

//--- src/lsu_cfg_pkg.sv
package lsu_cfg_pkg;

  ////////////////////////////////////////////////// Widths
  localparam int unsigned ADDR_W = 32;          // Bus and operand address
  localparam int unsigned DATA_W = 32;          // Data word
  localparam int unsigned BE_W   = DATA_W / 8;  // One enable per byte lane
  localparam int unsigned OFFS_W = $clog2(BE_W);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;
  typedef logic [OFFS_W-1:0] offset_t;   // Byte offset within a word

  ////////////////////////////////////////////////// Transaction limit
  // Outstanding bus transactions allowed at once
  // EX/WB lock-step rules are built around two
  localparam int unsigned LSU_DEPTH_DEFAULT = 2;

endpackage

//--- src/lsu_op_pkg.sv
package lsu_op_pkg;

  // Access size, same coding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_e;

  ////////////////////////////////////////////////// EX side
  typedef struct packed {
    lsu_cfg_pkg::addr_t operand_a;   // Base address
    lsu_cfg_pkg::addr_t operand_b;   // Offset, added when use_incr is set
    logic               use_incr;
    logic               we;          // Store when set
    mem_size_e          size;
    logic               sign_ext;    // Loads only
    logic               second_phase; // Second bus phase of a split access
    lsu_cfg_pkg::data_t wdata;       // Store data, not yet rotated
  } lsu_op_t;

  ////////////////////////////////////////////////// Bus
  typedef struct packed {
    lsu_cfg_pkg::addr_t addr;
    logic               we;
    lsu_cfg_pkg::be_t   be;
    lsu_cfg_pkg::data_t wdata;       // Already in lane position
  } bus_req_t;

  typedef struct packed {
    lsu_cfg_pkg::data_t rdata;       // Raw word, valid with rvalid only
    logic               err;
  } bus_resp_t;

  ////////////////////////////////////////////////// EX to WB
  typedef struct packed {
    mem_size_e            size;
    logic                 sign_ext;
    logic                 we;
    lsu_cfg_pkg::offset_t offset;    // Lane of the first byte
    logic                 last;      // Low on the first phase of a split access
  } lsu_wb_ctrl_t;

endpackage

//--- src/lsu_rdata_align.sv
`timescale 1ns/1ps

module lsu_rdata_align (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ex_update_i,
  input  lsu_op_pkg::lsu_wb_ctrl_t  wb_ctrl_i,
  input  logic                      rvalid_i,
  input  lsu_op_pkg::bus_resp_t     resp_i,
  output logic                      wb_valid_o,
  output lsu_cfg_pkg::data_t        wb_rdata_o,
  output logic                      wb_err_o
);

  import lsu_cfg_pkg::*;
  import lsu_op_pkg::*;

  lsu_wb_ctrl_t wb_ctrl_q;    // Control of the access now in WB
  logic         ctrl_seen_q;  // Some control captured since reset
  data_t        rdata_q;      // First phase word, or last load result
  data_t        rdata;
  data_t        rdata_sh;     // Response moved down to lane 0
  data_t        rdata_w;
  logic [15:0]  rdata_h;
  logic [7:0]   rdata_b;
  data_t        rdata_ext;    // Final aligned and extended value

  ////////////////////////////////////////////////// WB control
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_ctrl_q   <= '0;
      ctrl_seen_q <= 1'b0;
    end
    else if (ex_update_i)
    begin
      wb_ctrl_q   <= wb_ctrl_i;
      ctrl_seen_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////// Alignment
  assign rdata    = resp_i.rdata;
  assign rdata_sh = rdata >> {wb_ctrl_q.offset, 3'b000};

  // Word, low bytes come from the held first phase
  always_comb
  begin
    case (wb_ctrl_q.offset)
      2'd0:    rdata_w = rdata;
      2'd1:    rdata_w = {rdata[7:0],  rdata_q[31:8]};
      2'd2:    rdata_w = {rdata[15:0], rdata_q[31:16]};
      default: rdata_w = {rdata[23:0], rdata_q[31:24]};
    endcase
  end

  // Half at offset 3 spans two words
  assign rdata_h = (wb_ctrl_q.offset == 2'd3) ? {rdata[7:0], rdata_q[31:24]}
                                              : rdata_sh[15:0];
  assign rdata_b = rdata_sh[7:0];

  ////////////////////////////////////////////////// Extension
  always_comb
  begin
    case (wb_ctrl_q.size)
      size_byte: rdata_ext = {{24{wb_ctrl_q.sign_ext && rdata_b[7]}}, rdata_b};
      size_half: rdata_ext = {{16{wb_ctrl_q.sign_ext && rdata_h[15]}}, rdata_h};
      default:   rdata_ext = rdata_w;          // Word, nothing to extend
    endcase
  end

  ////////////////////////////////////////////////// Hold register
  always_ff @(posedge clk)
  begin
    if (rvalid_i && !wb_ctrl_q.we)
    begin
      if (!wb_ctrl_q.last)
        rdata_q <= rdata;                      // Keep raw word for assembly
      else
        rdata_q <= rdata_ext;
    end
  end

  ////////////////////////////////////////////////// Outputs
  assign wb_rdata_o = rvalid_i ? rdata_ext : rdata_q;
  assign wb_valid_o = rvalid_i && wb_ctrl_q.last;   // Once per access
  assign wb_err_o   = rvalid_i && resp_i.err;

  // Response needs a request that passed through EX
  a_rvalid_has_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> ctrl_seen_q)
    else $error("rvalid before any WB control was captured");

endmodule

//--- src/lsu_request_gen.sv
`timescale 1ns/1ps

module lsu_request_gen (
  input  logic                      ex_valid_i,
  input  lsu_op_pkg::lsu_op_t       ex_op_i,
  output logic                      misaligned_o,
  output lsu_op_pkg::bus_req_t      req_data_o,
  output lsu_op_pkg::lsu_wb_ctrl_t  wb_ctrl_o
);

  import lsu_cfg_pkg::*;
  import lsu_op_pkg::*;

  addr_t   addr;      // Effective address
  offset_t offset;    // Byte lane of the first byte
  be_t     be;
  data_t   wdata_rot; // Store data moved to its lanes

  ////////////////////////////////////////////////// Address
  assign addr   = ex_op_i.use_incr ? (ex_op_i.operand_a + ex_op_i.operand_b)
                                   : ex_op_i.operand_a;
  assign offset = addr[1:0];

  ////////////////////////////////////////////////// Byte enables
  // Shifts are 4 bits wide, so lanes past 3 fall off
  always_comb
  begin
    case (ex_op_i.size)
      size_byte:
      begin
        be = 4'b0001 << offset;
      end
      size_half:
      begin
        if (ex_op_i.second_phase)
          be = 4'b0001;                  // Upper byte of a half at offset 3
        else
          be = 4'b0011 << offset;        // Offset 3 leaves lane 3 only
      end
      default:
      begin
        if (ex_op_i.second_phase)
          be = ~(4'b1111 << offset);     // Lanes below the offset
        else
          be = 4'b1111 << offset;
      end
    endcase
  end

  ////////////////////////////////////////////////// Write data
  // Rotate left by whole bytes, the wrapped bytes serve the second phase
  always_comb
  begin
    case (offset)
      2'd0:    wdata_rot = ex_op_i.wdata;
      2'd1:    wdata_rot = {ex_op_i.wdata[23:0], ex_op_i.wdata[31:24]};
      2'd2:    wdata_rot = {ex_op_i.wdata[15:0], ex_op_i.wdata[31:16]};
      default: wdata_rot = {ex_op_i.wdata[7:0],  ex_op_i.wdata[31:8]};
    endcase
  end

  ////////////////////////////////////////////////// Split detection
  always_comb
  begin
    misaligned_o = 1'b0;
    if (ex_valid_i && !ex_op_i.second_phase)
    begin
      if (ex_op_i.size == size_word && offset != 2'd0)
        misaligned_o = 1'b1;                            // Word crosses the boundary
      else if (ex_op_i.size == size_half && offset == 2'd3)
        misaligned_o = 1'b1;                            // Half crosses the boundary
    end
  end

  ////////////////////////////////////////////////// Outputs
  // Second phase starts at lane 0 of the next word
  assign req_data_o.addr  = ex_op_i.second_phase ? {addr[31:2], 2'b00} : addr;
  assign req_data_o.we    = ex_op_i.we;
  assign req_data_o.be    = be;
  assign req_data_o.wdata = wdata_rot;

  assign wb_ctrl_o.size     = ex_op_i.size;
  assign wb_ctrl_o.sign_ext = ex_op_i.sign_ext;
  assign wb_ctrl_o.we       = ex_op_i.we;
  assign wb_ctrl_o.offset   = offset;
  assign wb_ctrl_o.last     = !misaligned_o;   // A first phase never ends the access

endmodule

//--- src/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
  parameter int unsigned DEPTH = lsu_cfg_pkg::LSU_DEPTH_DEFAULT  // Max outstanding transactions
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // EX stage
  input  logic                   ex_valid_i,
  input  lsu_op_pkg::lsu_op_t    ex_op_i,
  output logic                   ex_ready_o,
  output logic                   misaligned_o,    // Issuer must follow with a second phase

  // Data bus
  output logic                   bus_req_o,
  output lsu_op_pkg::bus_req_t   bus_req_data_o,
  input  logic                   bus_gnt_i,
  input  logic                   bus_rvalid_i,
  input  lsu_op_pkg::bus_resp_t  bus_resp_i,

  // WB stage
  output logic                   wb_valid_o,
  output lsu_cfg_pkg::data_t     wb_rdata_o,
  output logic                   wb_err_o,
  output lsu_cfg_pkg::addr_t     err_addr_o,      // Last granted address
  output logic                   busy_o
);

  import lsu_op_pkg::*;

  lsu_wb_ctrl_t wb_ctrl;      // Control of the op in EX, for WB
  logic         ex_update;    // Op leaves EX, WB control moves along

  ////////////////////////////////////////////////// EX side request
  lsu_request_gen u_request_gen (
    .ex_valid_i   (ex_valid_i),
    .ex_op_i      (ex_op_i),
    .misaligned_o (misaligned_o),
    .req_data_o   (bus_req_data_o),
    .wb_ctrl_o    (wb_ctrl)
  );

  ////////////////////////////////////////////////// Handshakes and counter
  lsu_txn_ctrl #(
    .DEPTH (DEPTH)
  ) u_txn_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_valid_i   (ex_valid_i),
    .misaligned_i (misaligned_o),
    .req_data_i   (bus_req_data_o),
    .bus_req_o    (bus_req_o),
    .bus_gnt_i    (bus_gnt_i),
    .bus_rvalid_i (bus_rvalid_i),
    .ex_ready_o   (ex_ready_o),
    .ex_update_o  (ex_update),
    .err_addr_o   (err_addr_o),
    .busy_o       (busy_o)
  );

  ////////////////////////////////////////////////// WB side
  lsu_rdata_align u_rdata_align (
    .clk         (clk),
    .rst_n       (rst_n),
    .ex_update_i (ex_update),
    .wb_ctrl_i   (wb_ctrl),
    .rvalid_i    (bus_rvalid_i),
    .resp_i      (bus_resp_i),
    .wb_valid_o  (wb_valid_o),
    .wb_rdata_o  (wb_rdata_o),
    .wb_err_o    (wb_err_o)
  );

endmodule

//--- src/lsu_txn_ctrl.sv
`timescale 1ns/1ps

module lsu_txn_ctrl #(
  parameter int unsigned DEPTH = lsu_cfg_pkg::LSU_DEPTH_DEFAULT
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ex_valid_i,
  input  logic                  misaligned_i,   // First phase of a split access
  input  lsu_op_pkg::bus_req_t  req_data_i,
  output logic                  bus_req_o,
  input  logic                  bus_gnt_i,
  input  logic                  bus_rvalid_i,
  output logic                  ex_ready_o,
  output logic                  ex_update_o,    // EX op done, WB control follows
  output lsu_cfg_pkg::addr_t    err_addr_o,
  output logic                  busy_o
);

  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [CNT_W-1:0] cnt_q;       // Outstanding transactions
  logic [CNT_W-1:0] cnt_d;
  logic             accept;      // Request taken by the bus
  logic             split_q;     // Between the two phases of a split access

  ////////////////////////////////////////////////// Request and readiness
  // No path from rvalid to the request
  assign bus_req_o = ex_valid_i && (cnt_q < DEPTH);
  assign accept    = bus_req_o && bus_gnt_i;

  // WB holds one access, so with one in flight EX and WB move in lock step
  always_comb
  begin
    if (!ex_valid_i)
      ex_ready_o = 1'b1;                       // Nothing to do
    else if (cnt_q == '0)
      ex_ready_o = accept;                     // WB is free
    else if (cnt_q == CNT_W'(1))
      ex_ready_o = accept && bus_rvalid_i;     // WB must drain as EX moves
    else
      ex_ready_o = bus_rvalid_i;               // Op already granted, waits for WB
  end

  assign ex_update_o = ex_ready_o && ex_valid_i;

  ////////////////////////////////////////////////// Counter
  always_comb
  begin
    case ({accept, bus_rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;          // Idle, or up and down together
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q   <= '0;
      split_q <= 1'b0;
    end
    else
    begin
      cnt_q <= cnt_d;
      if (ex_update_o)
        split_q <= misaligned_i;       // Set on the first phase, cleared by the second
    end
  end

  assign busy_o = (cnt_q != '0) || bus_req_o;

  ////////////////////////////////////////////////// Error address
  // Address of the newest granted request, for bus error reports
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      err_addr_o <= '0;
    else if (accept)
      err_addr_o <= req_data_i.addr;
  end

  ////////////////////////////////////////////////// Checks
  a_cnt_max: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= DEPTH)
    else $error("outstanding count above DEPTH");

  a_no_stray_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    bus_rvalid_i |-> cnt_q != '0)
    else $error("rvalid with nothing outstanding");

  // Issuer must hold its op, request must not drop before the grant
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_req_o && !bus_gnt_i) |=> bus_req_o && $stable(req_data_i))
    else $error("request changed while waiting for grant");

  // Issuer follows a first phase with its second phase, not a new split op
  a_second_phase: assert property (@(posedge clk) disable iff (!rst_n)
    (split_q && ex_update_o) |-> !misaligned_i)
    else $error("split access not completed by its second phase");

endmodule

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD     = 100,  // ns
  parameter int RST_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset leaves on a falling edge, away from the sampling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

//--- testbench/tb_lsu_top.sv
`timescale 1ns/1ps

module tb_lsu_top;

  import lsu_cfg_pkg::*;
  import lsu_op_pkg::*;

  localparam int N_RAND = 40;
  localparam int N_OPS  = 21 + N_RAND;   // Directed plus random accesses

  logic clk, rst_n, ex_valid, ex_ready, misaligned, bus_req, bus_gnt, bus_rvalid;
  logic wb_valid, wb_err, busy, hold_gnt;
  lsu_op_t   ex_op;
  bus_req_t  bus_req_data;
  bus_resp_t bus_resp;
  data_t     wb_rdata;
  addr_t     err_addr;

  integer seed;
  int     err_cnt, test_cnt, outstanding;
  logic [7:0] shadow[addr_t];             // Byte image of memory
  logic   exp_load_q[$], exp_err_q[$];    // One entry per access, in order
  data_t  exp_val_q[$];
  addr_t  exp_addr_q[$];
  logic   head_vld, head_load, head_err;
  data_t  head_val;
  addr_t  head_addr;

  tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  tb_mem_model u_mem (
    .clk(clk), .rst_n(rst_n), .req_i(bus_req), .req_data_i(bus_req_data),
    .hold_gnt_i(hold_gnt), .gnt_o(bus_gnt), .rvalid_o(bus_rvalid), .resp_o(bus_resp)
  );

  lsu_top #(.DEPTH(2)) dut0 (
    .clk(clk), .rst_n(rst_n), .ex_valid_i(ex_valid), .ex_op_i(ex_op),
    .ex_ready_o(ex_ready), .misaligned_o(misaligned), .bus_req_o(bus_req),
    .bus_req_data_o(bus_req_data), .bus_gnt_i(bus_gnt), .bus_rvalid_i(bus_rvalid),
    .bus_resp_i(bus_resp), .wb_valid_o(wb_valid), .wb_rdata_o(wb_rdata),
    .wb_err_o(wb_err), .err_addr_o(err_addr), .busy_o(busy)
  );

  ////////////////////////////////////////////////// Reference model
  function automatic logic [7:0] byte_at(addr_t a);
    data_t w;
    w = ({a[31:2], 2'b00} * 32'h9e37_79b1) ^ 32'h3c6e_f372;
    return shadow.exists(a) ? shadow[a] : w[8*a[1:0] +: 8];
  endfunction

  function automatic data_t load_expect(addr_t a, mem_size_e sz, logic sx);
    data_t v;
    v = '0;
    for (int i = 0; i < 4; i++)
      v[8*i +: 8] = byte_at(a + i);
    if (sz == size_byte)
      v = {{24{sx && v[7]}}, v[7:0]};     // Extend from the lane's top bit
    else if (sz == size_half)
      v = {{16{sx && v[15]}}, v[15:0]};
    return v;
  endfunction

  // Split rule: word off alignment, half at offset 3, first phase only
  function automatic logic split_expected(lsu_op_t op);
    addr_t a;
    a = op.use_incr ? op.operand_a + op.operand_b : op.operand_a;
    return !op.second_phase && ((op.size == size_word && a[1:0] != 2'd0) ||
                                (op.size == size_half && a[1:0] == 2'd3));
  endfunction

  task automatic refresh_head();
    head_vld  = exp_load_q.size() > 0;
    head_load = head_vld ? exp_load_q[0] : 1'b0;
    head_err  = head_vld ? exp_err_q[0]  : 1'b0;
    head_val  = head_vld ? exp_val_q[0]  : '0;
    head_addr = head_vld ? exp_addr_q[0] : '0;
  endtask

  ////////////////////////////////////////////////// Stimulus helpers
  task automatic issue_phase(input lsu_op_t op, output logic split);
    @(negedge clk);
    ex_valid = 1'b1;
    ex_op    = op;
    do
      @(posedge clk);
    while (!ex_ready);                     // Watchdog bounds this wait
    split = misaligned;
  endtask

  task automatic access(addr_t a, mem_size_e sz, logic we, logic sx, data_t wd);
    lsu_op_t op;
    logic    split;
    int      n;
    n = (sz == size_word) ? 4 : (sz == size_half) ? 2 : 1;
    op.operand_b    = $random(seed) & 32'h3f;
    op.use_incr     = $random(seed);
    op.operand_a    = op.use_incr ? a - op.operand_b : a;
    op.we           = we;
    op.size         = sz;
    op.sign_ext     = sx;
    op.second_phase = 1'b0;
    op.wdata        = wd;
    exp_load_q.push_back(!we);
    exp_err_q.push_back(a[31]);
    exp_addr_q.push_back(a);
    exp_val_q.push_back(we ? '0 : load_expect(a, sz, sx));
    if (we && !a[31])
      for (int i = 0; i < n; i++)
        shadow[a + i] = wd[8*i +: 8];      // Low bytes of the data, upward
    refresh_head();
    issue_phase(op, split);
    if (split)
    begin
      op.operand_a    = op.operand_a + 4;  // Issuer's second phase
      op.second_phase = 1'b1;
      issue_phase(op, split);
    end
  endtask

  task automatic drain();
    @(negedge clk);
    ex_valid = 1'b0;
    do
      @(posedge clk);
    while (busy);
  endtask

  task automatic report(string name);
    test_cnt++;
    $display("test %0d %s finished, errors so far %0d", test_cnt, name, err_cnt);
  endtask

  ////////////////////////////////////////////////// Bookkeeping
  always @(posedge clk)
  begin
    if (rst_n && wb_valid && exp_load_q.size() > 0)
    begin
      void'(exp_load_q.pop_front());
      void'(exp_err_q.pop_front());
      void'(exp_val_q.pop_front());
      void'(exp_addr_q.pop_front());
      refresh_head();
    end
  end

  always @(posedge clk or negedge rst_n)
    if (!rst_n)
      outstanding = 0;
    else
      outstanding = outstanding + int'(bus_req && bus_gnt) - int'(bus_rvalid);

  ////////////////////////////////////////////////// Checks
  a_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !bus_req && !wb_valid && !wb_err && !busy)
    else
    begin
      $display("outputs not idle after reset");
      err_cnt++;
    end

  a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid && head_load && !head_err) |-> wb_rdata == head_val)
    else
    begin
      $display("MISMATCH wb_rdata_o exp=%h got=%h", $sampled(head_val), $sampled(wb_rdata));
      err_cnt++;
    end

  a_split: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid |-> misaligned == split_expected(ex_op))
    else
    begin
      $display("MISMATCH misaligned_o exp=%h got=%h",
               split_expected($sampled(ex_op)), $sampled(misaligned));
      err_cnt++;
    end

  a_once: assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> head_vld)
    else
    begin
      $display("write-back without a pending access");
      err_cnt++;
    end

  a_err_flag: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> wb_err == head_err)
    else
    begin
      $display("MISMATCH wb_err_o exp=%h got=%h", $sampled(head_err), $sampled(wb_err));
      err_cnt++;
    end

  a_err_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid && head_err) |-> err_addr == head_addr)
    else
    begin
      $display("MISMATCH err_addr_o exp=%h got=%h", $sampled(head_addr), $sampled(err_addr));
      err_cnt++;
    end

  a_depth: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding <= 2 && (outstanding == 0 || busy))
    else
    begin
      $display("outstanding %0d above limit or busy low", outstanding);
      err_cnt++;
    end

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_req && !bus_gnt) |=> bus_req && $stable(bus_req_data))
    else
    begin
      $display("request dropped or changed before its grant");
      err_cnt++;
    end

  a_no_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_req && !bus_gnt) |-> !ex_ready)
    else
    begin
      $display("ex_ready_o high while the grant is held off");
      err_cnt++;
    end

  ////////////////////////////////////////////////// Watchdog
  initial
  begin
    #(N_OPS * 12 * 100);
    $display("timeout, accesses did not complete in time");
    $display("Errors found");
    $finish;
  end

  ////////////////////////////////////////////////// Tests
  initial
  begin
    seed = 72;
    ex_valid = 1'b0;
    ex_op    = '0;
    hold_gnt = 1'b0;
    err_cnt  = 0;
    test_cnt = 0;
    refresh_head();
    @(posedge rst_n);
    repeat (2) @(posedge clk);
    report("reset");

    access(32'h100, size_word, 1'b1, 1'b0, 32'h8765_4321);
    access(32'h100, size_word, 1'b0, 1'b0, '0);
    access(32'h104, size_half, 1'b1, 1'b0, 32'h0000_9abc);
    access(32'h104, size_half, 1'b0, 1'b1, '0);    // Sign extended
    access(32'h104, size_half, 1'b0, 1'b0, '0);
    access(32'h10b, size_byte, 1'b1, 1'b0, 32'h0000_00f0);
    access(32'h10b, size_byte, 1'b0, 1'b1, '0);
    access(32'h10b, size_byte, 1'b0, 1'b0, '0);
    access(32'h106, size_half, 1'b0, 1'b1, '0);    // Untouched memory
    drain();
    report("aligned");

    access(32'h111, size_word, 1'b1, 1'b0, 32'ha1b2_c3d4);
    access(32'h111, size_word, 1'b0, 1'b0, '0);
    access(32'h113, size_half, 1'b0, 1'b1, '0);
    access(32'h117, size_half, 1'b1, 1'b0, 32'h0000_7e80);
    access(32'h117, size_half, 1'b0, 1'b0, '0);
    access(32'h116, size_word, 1'b0, 1'b0, '0);
    access(32'h121, size_half, 1'b0, 1'b1, '0);    // Not split at offset 1
    access(32'h11e, size_word, 1'b0, 1'b0, '0);
    drain();
    report("misaligned");

    access(32'h8000_0040, size_word, 1'b0, 1'b0, '0);
    drain();
    access(32'h8000_0104, size_byte, 1'b0, 1'b1, '0);
    drain();
    report("bus error");

    hold_gnt = 1'b1;
    fork
      access(32'h130, size_word, 1'b1, 1'b0, 32'h0f1e_2d3c);
      begin
        repeat (6) @(negedge clk);
        hold_gnt = 1'b0;
      end
    join
    access(32'h130, size_word, 1'b0, 1'b0, '0);
    drain();
    report("back-pressure");

    repeat (N_RAND)
      access(32'h200 + ($unsigned($random(seed)) % 64),
             mem_size_e'($unsigned($random(seed)) % 3),
             $random(seed), $random(seed), $random(seed));
    drain();
    report("random and outstanding count");

    if (exp_load_q.size() != 0)
    begin
      $display("%0d accesses never reached write-back", exp_load_q.size());
      err_cnt++;
    end
    $display("tests %0d, errors %0d", test_cnt, err_cnt);
    if (err_cnt == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

//--- testbench/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  lsu_op_pkg::bus_req_t   req_data_i,
  input  logic                   hold_gnt_i,    // Forces back-pressure
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output lsu_op_pkg::bus_resp_t  resp_o
);

  import lsu_cfg_pkg::*;
  import lsu_op_pkg::*;

  integer seed;
  logic [1:0] wait_q;           // Cycles left before the next grant
  data_t      mem[addr_t];      // Written words only
  data_t      rsp_data[$];      // Pending responses, in order
  logic       rsp_err[$];
  int         rsp_due[$];
  int         cyc;
  int         last_due;

  // Unwritten words read a pattern of their whole address
  function automatic data_t fill_word(addr_t wa);
    return (wa * 32'h9e37_79b1) ^ 32'h3c6e_f372;
  endfunction

  initial seed = 72;

  assign gnt_o = req_i && !hold_gnt_i && (wait_q == 2'd0);

  always @(posedge clk or negedge rst_n)
  begin : bus_side
    addr_t wa;
    data_t word;
    int    due;
    if (!rst_n)
    begin
      wait_q   <= 2'd0;
      rvalid_o <= 1'b0;
      resp_o   <= '0;
      cyc      = 0;
      last_due = 0;
    end
    else
    begin
      rvalid_o <= 1'b0;
      if (rsp_due.size() > 0 && rsp_due[0] <= cyc)
      begin
        rvalid_o <= 1'b1;
        resp_o   <= {rsp_data.pop_front(), rsp_err.pop_front()};
        void'(rsp_due.pop_front());
      end
      if (req_i && gnt_o)
      begin
        wa   = {req_data_i.addr[31:2], 2'b00};
        word = mem.exists(wa) ? mem[wa] : fill_word(wa);
        if (req_data_i.we && !req_data_i.addr[31])
        begin
          for (int b = 0; b < 4; b++)
            if (req_data_i.be[b])
              word[8*b +: 8] = req_data_i.wdata[8*b +: 8];
          mem[wa] = word;
        end
        due = cyc + 1 + ($unsigned($random(seed)) % 3);   // 1 to 3 cycles
        if (due <= last_due)
          due = last_due + 1;                               // Keep order
        last_due = due;
        rsp_data.push_back(word);
        rsp_err.push_back(req_data_i.addr[31]);            // Error region
        rsp_due.push_back(due);
        wait_q <= 2'($unsigned($random(seed)) % 3);        // 0 to 2 cycles
      end
      else if (req_i && !hold_gnt_i && wait_q != 2'd0)
        wait_q <= wait_q - 2'd1;
      cyc++;
    end
  end

endmodule
